//--- blend_defines.svh
`ifndef BLEND_DEFINES_SVH
`define BLEND_DEFINES_SVH

// Raster index widths
`define BLEND_WBITS 12
`define BLEND_HBITS 12

// Pixel widths on the stream ports
`define BLEND_BG_WIDTH 32
`define BLEND_OUT_WIDTH 24

// Wishbone word address width and number of mapped registers
`define BLEND_WB_AW 4
`define BLEND_REG_COUNT 14

`endif

//--- blend_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "blend_defines.svh"

module blend_regs (
	input  wire                    clk,
	input  wire                    resetn,
	input  wire                    wb_cyc,
	input  wire                    wb_stb,
	input  wire                    wb_we,
	input  wire [`BLEND_WB_AW-1:0] wb_adr,
	input  wire [31:0]             wb_dat_w,
	output logic                   wb_ack,
	output logic [31:0]            wb_dat_r,
	output video_pkg::col_t        out_width,
	output video_pkg::row_t        out_height,
	output video_pkg::col_t        win0_left,
	output video_pkg::row_t        win0_top,
	output video_pkg::col_t        win0_width,
	output video_pkg::row_t        win0_height,
	output video_pkg::col_t        win1_left,
	output video_pkg::row_t        win1_top,
	output video_pkg::col_t        win1_width,
	output video_pkg::row_t        win1_height,
	output video_pkg::col_t        win2_left,
	output video_pkg::row_t        win2_top,
	output video_pkg::col_t        win2_width,
	output video_pkg::row_t        win2_height
);
	logic [`BLEND_WBITS-1:0] regs [`BLEND_REG_COUNT];
	wb_regs_pkg::reg_idx_e idx;
	logic req;
	logic mapped;

	assign idx = wb_regs_pkg::reg_idx_e'(wb_adr);
	// New request only while no ack is pending
	assign req = wb_cyc && wb_stb && !wb_ack;
	assign mapped = int'(wb_adr) < `BLEND_REG_COUNT;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < `BLEND_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (req && wb_we && mapped) begin
			regs[idx] <= wb_dat_w[`BLEND_WBITS-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			wb_ack <= 1'b0;
		else
			wb_ack <= req;
	end

	// Addresses past the map read as zero
	always_ff @(posedge clk) begin
		if (req)
			wb_dat_r <= mapped ? 32'(regs[idx]) : 32'd0;
	end

	////////////////////////////////////////
	// Register map outputs
	////////////////////////////////////////
	assign out_width   = regs[wb_regs_pkg::OUT_WIDTH];
	assign out_height  = video_pkg::row_t'(regs[wb_regs_pkg::OUT_HEIGHT]);
	assign win0_left   = regs[wb_regs_pkg::WIN0_LEFT];
	assign win0_top    = video_pkg::row_t'(regs[wb_regs_pkg::WIN0_TOP]);
	assign win0_width  = regs[wb_regs_pkg::WIN0_WIDTH];
	assign win0_height = video_pkg::row_t'(regs[wb_regs_pkg::WIN0_HEIGHT]);
	assign win1_left   = regs[wb_regs_pkg::WIN1_LEFT];
	assign win1_top    = video_pkg::row_t'(regs[wb_regs_pkg::WIN1_TOP]);
	assign win1_width  = regs[wb_regs_pkg::WIN1_WIDTH];
	assign win1_height = video_pkg::row_t'(regs[wb_regs_pkg::WIN1_HEIGHT]);
	assign win2_left   = regs[wb_regs_pkg::WIN2_LEFT];
	assign win2_top    = video_pkg::row_t'(regs[wb_regs_pkg::WIN2_TOP]);
	assign win2_width  = regs[wb_regs_pkg::WIN2_WIDTH];
	assign win2_height = video_pkg::row_t'(regs[wb_regs_pkg::WIN2_HEIGHT]);

	// Host keeps its request up until it sees the ack
	assert property (@(posedge clk) disable iff (!resetn)
		wb_ack |-> wb_cyc && wb_stb);

endmodule

`default_nettype wire

//--- overlay_blender.sv
`timescale 1ns/10ps
`default_nettype none
`include "blend_defines.svh"

module overlay_blender (
	input  wire                        clk,
	input  wire                        resetn,
	input  wire                        wb_cyc,
	input  wire                        wb_stb,
	input  wire                        wb_we,
	input  wire [`BLEND_WB_AW-1:0]     wb_adr,
	input  wire [31:0]                 wb_dat_w,
	output logic                       wb_ack,
	output logic [31:0]                wb_dat_r,
	input  wire                        s0_tvalid,
	input  wire [`BLEND_BG_WIDTH-1:0]  s0_tdata,
	input  wire                        s0_tuser,
	input  wire                        s0_tlast,
	output logic                       s0_tready,
	input  wire                        s1_tvalid,
	input  wire video_pkg::plane_t     s1_tdata,
	input  wire                        s1_tuser,
	input  wire                        s1_tlast,
	output logic                       s1_tready,
	input  wire                        s2_tvalid,
	input  wire video_pkg::plane_t     s2_tdata,
	input  wire                        s2_tuser,
	input  wire                        s2_tlast,
	output logic                       s2_tready,
	output logic                       m_tvalid,
	output logic [`BLEND_OUT_WIDTH-1:0] m_tdata,
	output logic                       m_tuser,
	output logic                       m_tlast,
	input  wire                        m_tready
);
	video_pkg::col_t out_width;
	video_pkg::row_t out_height;
	video_pkg::col_t win0_left;
	video_pkg::row_t win0_top;
	video_pkg::col_t win0_width;
	video_pkg::row_t win0_height;
	video_pkg::col_t win1_left;
	video_pkg::row_t win1_top;
	video_pkg::col_t win1_width;
	video_pkg::row_t win1_height;
	video_pkg::col_t win2_left;
	video_pkg::row_t win2_top;
	video_pkg::col_t win2_width;
	video_pkg::row_t win2_height;
	video_pkg::col_t col_idx;
	video_pkg::row_t row_idx;
	logic col_update;
	logic row_update;
	logic fsync;
	logic out_fire;
	logic first_pixel;
	logic last_pixel;
	logic out_ok;
	logic need0;
	logic need1;
	logic need2;

	blend_regs blend_regs_inst (.*);

	raster_sequencer raster_sequencer_inst (.*);

	// Trackers share the raster position, each with its own window
	window_tracker tracker0_inst (
		.*,
		.win_left(win0_left),
		.win_top(win0_top),
		.win_width(win0_width),
		.win_height(win0_height),
		.need(need0)
	);

	window_tracker tracker1_inst (
		.*,
		.win_left(win1_left),
		.win_top(win1_top),
		.win_width(win1_width),
		.win_height(win1_height),
		.need(need1)
	);

	window_tracker tracker2_inst (
		.*,
		.win_left(win2_left),
		.win_top(win2_top),
		.win_width(win2_width),
		.win_height(win2_height),
		.need(need2)
	);

	pixel_mixer pixel_mixer_inst (.*);

	// Inputs advance only together with an output beat
	assign s0_tready = out_fire && need0;
	assign s1_tready = out_fire && need1;
	assign s2_tready = out_fire && need2;

endmodule

`default_nettype wire

//--- pixel_mixer.sv
`timescale 1ns/10ps
`default_nettype none
`include "blend_defines.svh"

module pixel_mixer (
	input  wire                       clk,
	input  wire                       resetn,
	input  wire                       out_fire,
	input  wire                       first_pixel,
	input  wire                       last_pixel,
	input  wire                       s0_tvalid,
	input  wire [`BLEND_BG_WIDTH-1:0] s0_tdata,
	input  wire                       need0,
	input  wire                       s1_tvalid,
	input  wire video_pkg::plane_t    s1_tdata,
	input  wire                       need1,
	input  wire                       s2_tvalid,
	input  wire video_pkg::plane_t    s2_tdata,
	input  wire                       need2,
	input  wire                       m_tready,
	output logic                      out_ok,
	output logic                      m_tvalid,
	output video_pkg::rgb_t           m_tdata,
	output logic                      m_tuser,
	output logic                      m_tlast
);
	video_pkg::bg_pixel_u bg;
	video_pkg::rgb_t mix;

	assign bg = s0_tdata;

	// Every stream that covers this position must have a pixel ready
	assign out_ok = (!need0 || s0_tvalid) &&
		(!need1 || s1_tvalid) &&
		(!need2 || s2_tvalid);

	// Overlay present: red from background, planes fill green and blue
	always_comb begin
		if (need1 || need2) begin
			mix.red   = bg.argb.red;
			mix.green = need1 ? s1_tdata : 8'h00;
			mix.blue  = need2 ? s2_tdata : 8'h00;
		end else begin
			mix = bg.raw[`BLEND_OUT_WIDTH-1:0];
		end
	end

	////////////////////////////////////////
	// Output register stage
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_tvalid <= 1'b0;
			m_tuser  <= 1'b0;
			m_tlast  <= 1'b0;
		end else if (out_fire) begin
			m_tvalid <= 1'b1;
			m_tuser  <= first_pixel;
			m_tlast  <= last_pixel;
		end else if (m_tready) begin
			m_tvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (out_fire)
			m_tdata <= mix;
	end

	// A stalled beat keeps its data
	assert property (@(posedge clk) disable iff (!resetn)
		m_tvalid && !m_tready |=> $stable(m_tdata));

endmodule

`default_nettype wire

//--- raster_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module raster_sequencer (
	input  wire                  clk,
	input  wire                  resetn,
	input  wire video_pkg::col_t out_width,
	input  wire video_pkg::row_t out_height,
	input  wire                  out_ok,
	input  wire                  m_tready,
	input  wire                  s0_tvalid,
	input  wire                  s0_tuser,
	output video_pkg::col_t      col_idx,
	output video_pkg::row_t      row_idx,
	output logic                 col_update,
	output logic                 row_update,
	output logic                 fsync,
	output logic                 out_fire,
	output logic                 first_pixel,
	output logic                 last_pixel
);
	// Look-ahead counters, always one ahead of col_idx and row_idx
	video_pkg::col_t col_nxt;
	video_pkg::row_t row_nxt;
	logic last_line;
	logic gap0;
	logic gap1;
	logic streaming;

	assign out_fire    = streaming && out_ok && m_tready;
	assign col_update  = gap1 || out_fire;
	assign row_update  = gap1;
	assign fsync       = gap0 && last_line;
	assign first_pixel = (col_idx == '0) && (row_idx == '0);

	////////////////////////////////////////
	// Line gaps and streaming flag
	////////////////////////////////////////

	// After the last line, hold off until stream 0 offers its frame start
	always_ff @(posedge clk) begin
		if (!resetn) begin
			gap0 <= 1'b0;
			gap1 <= 1'b0;
		end else begin
			gap0 <= !gap0 && !gap1 && !streaming &&
				(!last_line || (s0_tvalid && s0_tuser));
			gap1 <= gap0;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			streaming <= 1'b0;
		else if (row_update)
			streaming <= 1'b1;
		else if (out_fire && last_pixel)
			streaming <= 1'b0;
	end

	////////////////////////////////////////
	// Column and row counters
	////////////////////////////////////////

	// All ones before a line, so the next index wraps to zero
	always_ff @(posedge clk) begin
		if (!resetn || gap0) begin
			col_idx <= '1;
			col_nxt <= '0;
		end else if (col_update) begin
			col_idx <= col_nxt;
			col_nxt <= col_nxt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn || fsync) begin
			row_idx <= '1;
			row_nxt <= '0;
		end else if (row_update) begin
			row_idx <= row_nxt;
			row_nxt <= row_nxt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			last_pixel <= 1'b0;
		else if (col_update)
			last_pixel <= (col_nxt == out_width - 1'b1);
	end

	// Set out of reset, so the first frame also waits for tuser
	always_ff @(posedge clk) begin
		if (!resetn)
			last_line <= 1'b1;
		else if (row_update)
			last_line <= (row_nxt == out_height - 1'b1);
	end

	// Beats only inside a line, never in a gap cycle
	assert property (@(posedge clk) disable iff (!resetn)
		out_fire |-> !gap0 && !gap1);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_overlay_blender -f sim.f \
	&& ./obj_dir/Vtb_overlay_blender > sim.log 2>&1
cat sim.log
grep -qx "STATUS: PASS" sim.log \
	&& echo "Simulation run passed" \
	|| { echo "Simulation run failed"; exit 1; }

//--- sim.f
+incdir+.
video_pkg.sv
wb_regs_pkg.sv
blend_regs.sv
raster_sequencer.sv
window_tracker.sv
pixel_mixer.sv
overlay_blender.sv
tb_overlay_blender.sv

//--- tb_overlay_blender.sv
`timescale 1ns/10ps
`default_nettype none
`include "blend_defines.svh"

module tb_overlay_blender;

	localparam int NUM_FRAMES = 8;

	logic clk;
	logic resetn;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`BLEND_WB_AW-1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic wb_ack;
	logic [31:0] wb_dat_r;
	logic s0_tvalid;
	logic [`BLEND_BG_WIDTH-1:0] s0_tdata;
	logic s0_tuser;
	logic s0_tlast;
	logic s0_tready;
	logic s1_tvalid;
	video_pkg::plane_t s1_tdata;
	logic s1_tuser;
	logic s1_tlast;
	logic s1_tready;
	logic s2_tvalid;
	video_pkg::plane_t s2_tdata;
	logic s2_tuser;
	logic s2_tlast;
	logic s2_tready;
	logic m_tvalid;
	video_pkg::rgb_t m_tdata;
	logic m_tuser;
	logic m_tlast;
	logic m_tready;

	// Frame geometry and windows of the frame in flight
	int fr_w [NUM_FRAMES];
	int fr_h [NUM_FRAMES];
	int cur_w;
	int cur_h;
	int wl [3];
	int wt [3];
	int ww [3];
	int wh [3];
	int reg_val [`BLEND_REG_COUNT];
	int area [3];
	int acc [3];

	// Model output and source pixels
	video_pkg::rgb_t exp_q [$];
	logic [31:0] s0_q [$];
	video_pkg::plane_t s1_q [$];
	video_pkg::plane_t s2_q [$];

	logic frame_active;
	int out_cnt;
	int checks;
	int errors;
	int cycles;
	int limit;
	logic take0;
	logic take1;
	logic take2;
	int pos;
	logic stall_held;
	video_pkg::rgb_t stall_data;

	overlay_blender overlay_blender_inst (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////
	task automatic check_rgb(input string name, input video_pkg::rgb_t got,
		input video_pkg::rgb_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at time %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Window covers left .. left+width-1, and the same for rows
	function automatic logic covers(input int k, input int c, input int r);
		return c >= wl[k] && c < wl[k] + ww[k] && r >= wt[k] && r < wt[k] + wh[k];
	endfunction

	task automatic count_accept(input int k, input int p);
		if (p >= cur_w * cur_h || !covers(k, p % cur_w, p / cur_w)) begin
			errors++;
			$display("Stream %0d beat accepted outside its window at time %0t", k, $time);
		end
		acc[k]++;
	endtask

	////////////////////////////////////////
	// Monitor, sources and sink
	////////////////////////////////////////
	always @(posedge clk) begin
		take0 = s0_tvalid && s0_tready;
		take1 = s1_tvalid && s1_tready;
		take2 = s2_tvalid && s2_tready;
		// Inputs move only with a beat, so stream 0's count is the raster position
		pos = acc[0];
		if (m_tvalid && m_tready) begin
			if (!frame_active || out_cnt >= cur_w * cur_h) begin
				errors++;
				$display("Output beat at time %0t belongs to no frame", $time);
			end else begin
				check_rgb("m_tdata", m_tdata, exp_q[out_cnt]);
				check_flag("m_tuser", m_tuser, out_cnt == 0);
				check_flag("m_tlast", m_tlast, (out_cnt % cur_w) == cur_w - 1);
			end
			out_cnt++;
		end
		if (stall_held)
			check_rgb("m_tdata while stalled", m_tdata, stall_data);
		stall_held = m_tvalid && !m_tready;
		stall_data = m_tdata;
		if (take0)
			count_accept(0, pos);
		if (take1)
			count_accept(1, pos);
		if (take2)
			count_accept(2, pos);

		#1;
		m_tready = ($urandom % 4) != 0;
		if (take0)
			void'(s0_q.pop_front());
		if (take0 || !s0_tvalid) begin
			s0_tvalid = frame_active && s0_q.size() > 0 && ($urandom % 4) != 0;
			if (s0_tvalid) begin
				s0_tdata = s0_q[0];
				s0_tuser = acc[0] == 0;
			end
		end
		if (take1)
			void'(s1_q.pop_front());
		if (take1 || !s1_tvalid) begin
			s1_tvalid = frame_active && s1_q.size() > 0 && ($urandom % 3) != 0;
			if (s1_tvalid) begin
				s1_tdata = s1_q[0];
				s1_tuser = acc[1] == 0;
			end
		end
		if (take2)
			void'(s2_q.pop_front());
		if (take2 || !s2_tvalid) begin
			s2_tvalid = frame_active && s2_q.size() > 0 && ($urandom % 3) != 0;
			if (s2_tvalid) begin
				s2_tdata = s2_q[0];
				s2_tuser = acc[2] == 0;
			end
		end
	end

	////////////////////////////////////////
	// Wishbone host
	////////////////////////////////////////
	task automatic wb_write(input logic [`BLEND_WB_AW-1:0] adr, input logic [31:0] data);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = data;
		do @(posedge clk); while (!wb_ack);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(posedge clk);
	endtask

	task automatic wb_read(input logic [`BLEND_WB_AW-1:0] adr, output logic [31:0] data);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		do @(posedge clk); while (!wb_ack);
		data = wb_dat_r;
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(posedge clk);
	endtask

	// Window 0 always spans the raster, overlays may be empty or clipped
	task automatic pick_windows();
		wl[0] = 0;
		wt[0] = 0;
		ww[0] = cur_w + int'($urandom % 4);
		wh[0] = cur_h + int'($urandom % 3);
		for (int k = 1; k < 3; k++) begin
			wl[k] = int'($urandom % (cur_w + 2));
			wt[k] = int'($urandom % (cur_h + 1));
			ww[k] = int'($urandom % (cur_w + 1));
			wh[k] = ($urandom % 6 == 0) ? 0 : 1 + int'($urandom % cur_h);
		end
	endtask

	task automatic program_registers();
		logic [31:0] data;
		reg_val[0] = cur_w;
		reg_val[1] = cur_h;
		for (int k = 0; k < 3; k++) begin
			reg_val[2 + 4 * k] = wl[k];
			reg_val[3 + 4 * k] = wt[k];
			reg_val[4 + 4 * k] = ww[k];
			reg_val[5 + 4 * k] = wh[k];
		end
		for (int a = 0; a < `BLEND_REG_COUNT; a++)
			wb_write(a[`BLEND_WB_AW-1:0], reg_val[a]);
		// Unmapped addresses must swallow writes
		wb_write(4'd14, $urandom);
		wb_write(4'd15, $urandom);
		for (int a = 0; a < 16; a++) begin
			wb_read(a[`BLEND_WB_AW-1:0], data);
			check_word("wb_dat_r", data, (a < `BLEND_REG_COUNT) ? reg_val[a] : 0);
		end
	endtask

	task automatic build_model();
		video_pkg::argb_t bg;
		video_pkg::plane_t p1;
		video_pkg::plane_t p2;
		video_pkg::rgb_t px;
		exp_q.delete();
		s0_q.delete();
		s1_q.delete();
		s2_q.delete();
		for (int k = 0; k < 3; k++) begin
			area[k] = 0;
			acc[k] = 0;
		end
		for (int r = 0; r < cur_h; r++) begin
			for (int c = 0; c < cur_w; c++) begin
				bg = $urandom;
				p1 = 8'h00;
				p2 = 8'h00;
				if (covers(0, c, r)) begin
					s0_q.push_back(bg);
					area[0]++;
				end
				if (covers(1, c, r)) begin
					p1 = $urandom;
					s1_q.push_back(p1);
					area[1]++;
				end
				if (covers(2, c, r)) begin
					p2 = $urandom;
					s2_q.push_back(p2);
					area[2]++;
				end
				px.red = bg.red;
				px.green = (covers(1, c, r) || covers(2, c, r)) ? p1 : bg.green;
				px.blue = (covers(1, c, r) || covers(2, c, r)) ? p2 : bg.blue;
				exp_q.push_back(px);
			end
		end
	endtask

	task automatic run_frame(input int f);
		cur_w = fr_w[f];
		cur_h = fr_h[f];
		pick_windows();
		program_registers();
		build_model();
		out_cnt = 0;
		frame_active = 1'b1;
		while (out_cnt < cur_w * cur_h)
			@(posedge clk);
		repeat (6) @(posedge clk);
		frame_active = 1'b0;
		if (out_cnt != cur_w * cur_h) begin
			errors++;
			$display("Frame %0d gave %0d beats instead of %0d", f, out_cnt, cur_w * cur_h);
		end
		for (int k = 0; k < 3; k++) begin
			if (acc[k] != area[k]) begin
				errors++;
				$display("Frame %0d: stream %0d gave %0d beats, window area is %0d",
					f, k, acc[k], area[k]);
			end
		end
	endtask

	initial begin
		int total;
		void'($urandom(23));
		resetn = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		s0_tvalid = 1'b0;
		s0_tdata = '0;
		s0_tuser = 1'b0;
		s0_tlast = 1'b0;
		s1_tvalid = 1'b0;
		s1_tdata = '0;
		s1_tuser = 1'b0;
		s1_tlast = 1'b0;
		s2_tvalid = 1'b0;
		s2_tdata = '0;
		s2_tuser = 1'b0;
		s2_tlast = 1'b0;
		m_tready = 1'b0;
		frame_active = 1'b0;
		stall_held = 1'b0;
		checks = 0;
		errors = 0;
		cycles = 0;
		out_cnt = 0;
		cur_w = 1;
		cur_h = 1;
		total = 0;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			fr_w[f] = 4 + int'($urandom % 9);
			fr_h[f] = 3 + int'($urandom % 6);
			total += fr_w[f] * fr_h[f];
		end
		limit = 40 * total + 2000;

		repeat (16) @(posedge clk);
		#1 resetn = 1'b1;
		@(posedge clk);
		check_flag("m_tvalid", m_tvalid, 1'b0);
		check_flag("m_tuser", m_tuser, 1'b0);
		check_flag("m_tlast", m_tlast, 1'b0);
		check_flag("wb_ack", wb_ack, 1'b0);
		check_flag("s0_tready", s0_tready, 1'b0);
		check_flag("s1_tready", s1_tready, 1'b0);
		check_flag("s2_tready", s2_tready, 1'b0);

		for (int f = 0; f < NUM_FRAMES; f++)
			run_frame(f);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- video_pkg.sv
`default_nettype none
`include "blend_defines.svh"

package video_pkg;

	typedef logic [`BLEND_WBITS-1:0] col_t;
	typedef logic [`BLEND_HBITS-1:0] row_t;

	// One byte per overlay plane pixel
	typedef logic [7:0] plane_t;

	// Background pixel, alpha in the top byte
	typedef struct packed {
		logic [7:0] alpha;
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} argb_t;

	// Same word, as fields or as raw bits
	typedef union packed {
		argb_t argb;
		logic [`BLEND_BG_WIDTH-1:0] raw;
	} bg_pixel_u;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

endpackage

`default_nettype wire

//--- wb_regs_pkg.sv
`default_nettype none
`include "blend_defines.svh"

package wb_regs_pkg;

	// Word addresses, counted from zero
	typedef enum logic [`BLEND_WB_AW-1:0] {
		OUT_WIDTH,
		OUT_HEIGHT,
		WIN0_LEFT,
		WIN0_TOP,
		WIN0_WIDTH,
		WIN0_HEIGHT,
		WIN1_LEFT,
		WIN1_TOP,
		WIN1_WIDTH,
		WIN1_HEIGHT,
		WIN2_LEFT,
		WIN2_TOP,
		WIN2_WIDTH,
		WIN2_HEIGHT
	} reg_idx_e;

endpackage

`default_nettype wire

//--- window_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module window_tracker (
	input  wire                  clk,
	input  wire                  resetn,
	input  wire                  fsync,
	input  wire video_pkg::col_t col_idx,
	input  wire                  col_update,
	input  wire video_pkg::row_t row_idx,
	input  wire                  row_update,
	input  wire video_pkg::col_t win_left,
	input  wire video_pkg::row_t win_top,
	input  wire video_pkg::col_t win_width,
	input  wire video_pkg::row_t win_height,
	output logic                 need
);
	video_pkg::col_t col_look;
	video_pkg::row_t row_look;
	video_pkg::col_t col_off;
	video_pkg::row_t row_off;
	logic col_hit;
	logic row_hit;
	logic h_in;
	logic v_in;

	// Index that becomes current on the next update strobe
	assign col_look = col_idx + 1'b1;
	assign row_look = row_idx + 1'b1;

	// Offset compare avoids overflow of left plus width
	assign col_off = col_look - win_left;
	assign row_off = row_look - win_top;
	assign col_hit = (col_look >= win_left) && (col_off < win_width);
	assign row_hit = (row_look >= win_top) && (row_off < win_height);

	always_ff @(posedge clk) begin
		if (!resetn || fsync)
			h_in <= 1'b0;
		else if (col_update)
			h_in <= col_hit;
	end

	always_ff @(posedge clk) begin
		if (!resetn || fsync)
			v_in <= 1'b0;
		else if (row_update)
			v_in <= row_hit;
	end

	assign need = h_in && v_in;

endmodule

`default_nettype wire
